//--- spiMaster.f
hdl/spiBusRegPkg.sv
hdl/spiLinkPkg.sv
hdl/spiBitShifter.sv
hdl/spiTransEngine.sv
hdl/ctrlStsRegBI.sv
hdl/spiMaster.sv
verification/spiSlaveModel.sv
verification/spiMasterTb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  # packages first, the link package uses the register package
  - hdl/spiBusRegPkg.sv
  - hdl/spiLinkPkg.sv
  # design, leaves before the top level
  - hdl/spiBitShifter.sv
  - hdl/spiTransEngine.sv
  - hdl/ctrlStsRegBI.sv
  - hdl/spiMaster.sv
  # testbench
  - target: test
    files:
      - verification/spiSlaveModel.sv
      - verification/spiMasterTb.sv

//--- verification/spiMasterTb.sv
`timescale 1ns/1ps

module spiMasterTb;

  ////////////////////////////////////////
  // timing and limits
  ////////////////////////////////////////

  // worst frame is ten bit times of two halves at divider FF, 7 ns clock
  localparam int frameNs     = 10 * 2 * 256 * 7;
  // frame plus sync, polling and register access overhead
  localparam int rowBudgetNs = frameNs + 2000;
  // one poll costs two busClk cycles
  localparam int maxPolls    = frameNs / 20 + 200;
  // busClk cycles between the two starts of a double start
  localparam int doubleGap   = 20;
  // busClk cycles the bus reset outlasts its cause
  localparam int rstHold     = 6;

  typedef enum logic [2:0] {
    opWrite,
    opReadCheck,
    opTransfer,
    opDoubleStart,
    opSwReset
  } tbOp;

  // one row of the stimulus table
  typedef struct packed {
    tbOp                  op;
    spiBusRegPkg::regAddr addr;
    spiBusRegPkg::regByte data;
    spiBusRegPkg::regByte expected;
  } tableRow;

  logic                   busClk;
  logic                   spiSysClk;
  logic                   rstFromWire;
  spiBusRegPkg::regBusReq busReq;
  spiBusRegPkg::regByte   dataOut;
  logic                   rstSyncToBusClkOut;
  logic                   spiClk;
  logic                   spiMosi;
  logic                   spiCsN;
  logic                   spiMiso;

  tableRow              stimTable[$];
  logic                 tableBuilt;
  integer               seed;
  // predicted content of the slave loop register
  spiBusRegPkg::regByte slaveLast;
  int                   checkCount;
  int                   errorCount;
  int                   rowErrors;
  int                   csFalls;
  // bus reset length seen after the wire reset
  int                   wireRstCycles;

  ////////////////////////////////////////
  // clocks, DUT and slave
  ////////////////////////////////////////

  always #5 busClk = ~busClk;
  always #3.5 spiSysClk = ~spiSysClk;

  // one falling chip select per frame
  always @(negedge spiCsN) begin
    csFalls = csFalls + 1;
  end

  spiMaster #(
    .rstHoldCycles (rstHold),
    .startStretch  (6)
  ) u_dut (
    .busClk             (busClk),
    .spiSysClk          (spiSysClk),
    .rstFromWire        (rstFromWire),
    .busReq             (busReq),
    .spiMiso            (spiMiso),
    .dataOut            (dataOut),
    .rstSyncToBusClkOut (rstSyncToBusClkOut),
    .spiClk             (spiClk),
    .spiMosi            (spiMosi),
    .spiCsN             (spiCsN)
  );

  spiSlaveModel u_slave (
    .rstFromWire (rstFromWire),
    .spiClk      (spiClk),
    .spiMosi     (spiMosi),
    .spiCsN      (spiCsN),
    .spiMiso     (spiMiso)
  );

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic checkRegByte(input string name, input spiBusRegPkg::regByte got,
                              input spiBusRegPkg::regByte exp);
    checkCount = checkCount + 1;
    if (got !== exp) begin
      errorCount = errorCount + 1;
      rowErrors  = rowErrors + 1;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkCsCount(input string name, input int got, input int exp);
    checkCount = checkCount + 1;
    if (got !== exp) begin
      errorCount = errorCount + 1;
      rowErrors  = rowErrors + 1;
      $display("ERR %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    checkCount = checkCount + 1;
    if (got !== exp) begin
      errorCount = errorCount + 1;
      rowErrors  = rowErrors + 1;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkResetCycles(input string name, input int got, input int exp);
    checkCount = checkCount + 1;
    if (got !== exp) begin
      errorCount = errorCount + 1;
      rowErrors  = rowErrors + 1;
      $display("ERR %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  // falling busClk edges until the bus reset drops, from the end of its cause
  task automatic measureReset(output int cycles);
    cycles = 0;
    while (rstSyncToBusClkOut === 1'b1 && cycles < 4 * rstHold) begin
      @(negedge busClk);
      cycles = cycles + 1;
    end
  endtask

  ////////////////////////////////////////
  // register bus access
  ////////////////////////////////////////

  // drive on falling busClk, the DUT takes it on the next rising edge
  task automatic busWrite(input spiBusRegPkg::regAddr addr, input spiBusRegPkg::regByte data);
    @(negedge busClk);
    busReq.address       = addr;
    busReq.dataIn        = data;
    busReq.writeEn       = 1'b1;
    busReq.strobe        = 1'b1;
    busReq.ctrlStsRegSel = 1'b1;
    @(negedge busClk);
    busReq.writeEn = 1'b0;
    busReq.strobe  = 1'b0;
  endtask

  // dataOut is combinational, sampled mid cycle where no clock edge falls
  task automatic busRead(input spiBusRegPkg::regAddr addr,
                         output spiBusRegPkg::regByte data);
    @(negedge busClk);
    busReq.address       = addr;
    busReq.writeEn       = 1'b0;
    busReq.strobe        = 1'b1;
    busReq.ctrlStsRegSel = 1'b1;
    @(negedge busClk);
    data          = dataOut;
    busReq.strobe = 1'b0;
  endtask

  ////////////////////////////////////////
  // transfer sequence
  ////////////////////////////////////////

  task automatic runTransfer(input tableRow row, input logic twice);
    int                   csBefore;
    int                   polls;
    spiBusRegPkg::regByte rd;
    csBefore = csFalls;
    busWrite(spiBusRegPkg::directDataRegAddr, row.data);
    busWrite(spiBusRegPkg::transCtrlRegAddr, 8'h01);
    // status must already be set on the first read
    busRead(spiBusRegPkg::transStsRegAddr, rd);
    checkRegByte("transSts first read", rd, 8'h01);
    if (twice) begin
      // second start well after the first stretch, engine is mid frame
      repeat (doubleGap) @(negedge busClk);
      busWrite(spiBusRegPkg::transCtrlRegAddr, 8'h01);
    end
    polls = 0;
    busRead(spiBusRegPkg::transStsRegAddr, rd);
    while (rd !== 8'h00 && polls < maxPolls) begin
      polls = polls + 1;
      busRead(spiBusRegPkg::transStsRegAddr, rd);
    end
    if (rd !== 8'h00) begin
      errorCount = errorCount + 1;
      rowErrors  = rowErrors + 1;
      $display("transfer never finished, status still set after %0d polls", polls);
    end else begin
      busRead(spiBusRegPkg::directDataRegAddr, rd);
      checkRegByte("directData received", rd, row.expected);
      checkCsCount("spiCsN frames", csFalls - csBefore, 1);
    end
  endtask

  function automatic string opName(input tbOp op);
    case (op)
      opWrite:       return "write";
      opReadCheck:   return "read-check";
      opTransfer:    return "transfer";
      opDoubleStart: return "double start";
      opSwReset:     return "software reset";
      default:       return "unknown";
    endcase
  endfunction

  task automatic runRow(input int idx, input tableRow row);
    spiBusRegPkg::regByte rd;
    int                   rstCycles;
    rowErrors = 0;
    case (row.op)
      opWrite: busWrite(row.addr, row.data);
      opReadCheck: begin
        busRead(row.addr, rd);
        checkRegByte($sformatf("dataOut@%h", row.addr), rd, row.expected);
      end
      opTransfer:    runTransfer(row, 1'b0);
      opDoubleStart: runTransfer(row, 1'b1);
      opSwReset: begin
        busWrite(row.addr, row.data);
        // reset is already up here, count the cycles until it drains
        measureReset(rstCycles);
        checkResetCycles("rstSyncToBusClkOut cycles", rstCycles, rstHold);
      end
      default: ;
    endcase
    if (rowErrors == 0) begin
      $display("row %0d %s ok", idx, opName(row.op));
    end else begin
      $display("row %0d %s had %0d error(s)", idx, opName(row.op), rowErrors);
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic addRow(input tbOp op, input spiBusRegPkg::regAddr addr,
                        input spiBusRegPkg::regByte data, input spiBusRegPkg::regByte expected);
    tableRow row;
    row.op       = op;
    row.addr     = addr;
    row.data     = data;
    row.expected = expected;
    stimTable.push_back(row);
  endtask

  // slave returns what it held, then holds the byte just sent
  task automatic addTransfer(input tbOp op);
    int                   randWord;
    spiBusRegPkg::regByte data;
    randWord = $random(seed);
    data     = randWord[7:0];
    addRow(op, spiBusRegPkg::directDataRegAddr, data, slaveLast);
    slaveLast = data;
  endtask

  task automatic buildTable();
    seed      = 1400;
    slaveLast = 8'hA5;
    // values straight after reset, unused addresses read 0
    addRow(opReadCheck, spiBusRegPkg::versionRegAddr, 8'h00, 8'h01);
    addRow(opReadCheck, spiBusRegPkg::transStsRegAddr, 8'h00, 8'h00);
    addRow(opReadCheck, spiBusRegPkg::clkDelRegAddr, 8'h00, 8'h04);
    addRow(opReadCheck, spiBusRegPkg::controlRegAddr, 8'h00, 8'h00);
    addRow(opReadCheck, 8'h02, 8'h00, 8'h00);
    addRow(opReadCheck, 8'h05, 8'h00, 8'h00);
    addRow(opReadCheck, 8'h0C, 8'h00, 8'h00);
    // divider readback and a data register write
    addRow(opWrite, spiBusRegPkg::clkDelRegAddr, 8'h5C, 8'h00);
    addRow(opReadCheck, spiBusRegPkg::clkDelRegAddr, 8'h00, 8'h5C);
    addRow(opWrite, spiBusRegPkg::directDataRegAddr, 8'h3E, 8'h00);
    // transfers at three dividers
    addRow(opWrite, spiBusRegPkg::clkDelRegAddr, 8'h00, 8'h00);
    addTransfer(opTransfer);
    addTransfer(opTransfer);
    addRow(opWrite, spiBusRegPkg::clkDelRegAddr, 8'h04, 8'h00);
    addTransfer(opTransfer);
    addTransfer(opTransfer);
    addRow(opWrite, spiBusRegPkg::clkDelRegAddr, 8'h13, 8'h00);
    addTransfer(opTransfer);
    // start while busy gives one frame only
    addTransfer(opDoubleStart);
    // software reset brings the divider back, slave keeps its content
    addRow(opReadCheck, spiBusRegPkg::clkDelRegAddr, 8'h00, 8'h13);
    addRow(opSwReset, spiBusRegPkg::controlRegAddr, 8'h01, 8'h00);
    addRow(opReadCheck, spiBusRegPkg::clkDelRegAddr, 8'h00, 8'h04);
    addRow(opReadCheck, spiBusRegPkg::transStsRegAddr, 8'h00, 8'h00);
    addTransfer(opTransfer);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    busClk      = 1'b0;
    spiSysClk   = 1'b0;
    rstFromWire = 1'b0;
    busReq      = '0;
    tableBuilt  = 1'b0;
    checkCount  = 0;
    errorCount  = 0;
    rowErrors   = 0;
    csFalls     = 0;
    buildTable();
    tableBuilt = 1'b1;
    // wire reset for four busClk cycles
    @(negedge busClk);
    rstFromWire = 1'b1;
    repeat (4) @(negedge busClk);
    rstFromWire = 1'b0;
    // bus reset holds on after the wire, SPI side idles once it is gone
    measureReset(wireRstCycles);
    checkResetCycles("rstSyncToBusClkOut cycles", wireRstCycles, rstHold);
    @(negedge busClk);
    checkLevel("spiCsN", spiCsN, 1'b1);
    checkLevel("spiClk", spiClk, 1'b0);
    if (rowErrors == 0) begin
      $display("wire reset ok");
    end else begin
      $display("wire reset had %0d error(s)", rowErrors);
    end
    foreach (stimTable[i]) begin
      runRow(i, stimTable[i]);
    end
    $display("rows %0d, checks %0d, errors %0d", stimTable.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // limit scales with the table length
  initial begin
    wait (tableBuilt === 1'b1);
    #(stimTable.size() * rowBudgetNs + 1000);
    $display("watchdog expired, the run did not finish in time");
    $display("test failed");
    $finish;
  end

endmodule

//--- verification/spiSlaveModel.sv
`timescale 1ns/1ps

module spiSlaveModel (
  input  logic rstFromWire,
  input  logic spiClk,
  input  logic spiMosi,
  input  logic spiCsN,
  output logic spiMiso
);

  // content the slave holds before the first frame
  localparam spiBusRegPkg::regByte presetByte = 8'hA5;

  // loop shift register, MSB drives MISO
  spiBusRegPkg::regByte loopReg;
  // MOSI bit taken on the rising edge
  logic                 mosiBit;

  // mode 0, sample on rising spiClk
  always @(posedge spiClk) begin
    if (!spiCsN) begin
      mosiBit <= spiMosi;
    end
  end

  // shift on falling spiClk, after eight bits the register holds the byte sent
  always @(negedge spiClk or posedge rstFromWire) begin
    if (rstFromWire) begin
      loopReg <= presetByte;
    end else if (!spiCsN) begin
      loopReg <= {loopReg[6:0], mosiBit};
    end
  end

  // first bit is valid before the first rising edge
  assign spiMiso = loopReg[7];

endmodule

//--- hdl/spiMaster.sv
`timescale 1ns/1ps

module spiMaster #(
  // busClk cycles the bus reset outlasts its cause
  parameter int rstHoldCycles = 6,
  // busClk cycles the start request is held, scales with clock ratio
  parameter int startStretch  = 6
) (
  input  logic                   busClk,
  input  logic                   spiSysClk,
  input  logic                   rstFromWire,
  input  spiBusRegPkg::regBusReq busReq,
  input  logic                   spiMiso,
  output spiBusRegPkg::regByte   dataOut,
  output logic                   rstSyncToBusClkOut,
  output logic                   spiClk,
  output logic                   spiMosi,
  output logic                   spiCsN
);

  // links between the two clock domains
  logic                     rstSyncToSpiClkOut;
  spiLinkPkg::spiXferCtrl   xferCtrl;
  spiLinkPkg::spiXferStatus xferStatus;

  ctrlStsRegBI #(
    .rstHoldCycles (rstHoldCycles),
    .startStretch  (startStretch)
  ) u_ctrlStsRegBI (
    .busClk             (busClk),
    .spiSysClk          (spiSysClk),
    .rstFromWire        (rstFromWire),
    .busReq             (busReq),
    .xferStatus         (xferStatus),
    .dataOut            (dataOut),
    .rstSyncToBusClkOut (rstSyncToBusClkOut),
    .rstSyncToSpiClkOut (rstSyncToSpiClkOut),
    .xferCtrl           (xferCtrl)
  );

  spiTransEngine u_spiTransEngine (
    .spiSysClk          (spiSysClk),
    .rstSyncToSpiClkOut (rstSyncToSpiClkOut),
    .xferCtrl           (xferCtrl),
    .spiMiso            (spiMiso),
    .xferStatus         (xferStatus),
    .spiClk             (spiClk),
    .spiMosi            (spiMosi),
    .spiCsN             (spiCsN)
  );

endmodule

//--- hdl/ctrlStsRegBI.sv
`timescale 1ns/1ps

module ctrlStsRegBI #(
  parameter int rstHoldCycles = 6,
  parameter int startStretch  = 6
) (
  input  logic                     busClk,
  input  logic                     spiSysClk,
  input  logic                     rstFromWire,
  input  spiBusRegPkg::regBusReq   busReq,
  input  spiLinkPkg::spiXferStatus xferStatus,
  output spiBusRegPkg::regByte     dataOut,
  output logic                     rstSyncToBusClkOut,
  output logic                     rstSyncToSpiClkOut,
  output spiLinkPkg::spiXferCtrl   xferCtrl
);

  // decoded host writes
  logic regWr;
  logic swRstWr;
  logic startWr;

  // bus side registers
  spiBusRegPkg::regByte clkDelReg;
  spiBusRegPkg::regByte txDataReg;
  spiBusRegPkg::regByte rxDataReg;
  logic                 startReq;
  logic                 xferStsReg;

  // reset generation
  logic [rstHoldCycles-1:0] rstShift;
  logic                     rstSpiMeta;

  // start path toward spiSysClk
  logic [startStretch-1:0] startShift;
  logic [2:0]              startSync;
  logic                    startPulse;
  spiBusRegPkg::regByte    txDataSpi;
  spiLinkPkg::spiClkDiv    clkDelaySpi;

  // busy path back to busClk
  logic [2:0] busySync;

  ////////////////////////////////////////
  // host write decode
  ////////////////////////////////////////

  // a write needs strobe, writeEn and select in the same cycle
  assign regWr = busReq.strobe & busReq.writeEn & busReq.ctrlStsRegSel;

  // software reset, bit 0 of the control register
  assign swRstWr = regWr && (busReq.address == spiBusRegPkg::controlRegAddr) &&
                   busReq.dataIn[spiBusRegPkg::swRstBit];

  // transfer start, bit 0 of the transfer control register
  assign startWr = regWr && (busReq.address == spiBusRegPkg::transCtrlRegAddr) &&
                   busReq.dataIn[spiBusRegPkg::transStartBit];

  always_ff @(posedge busClk) begin
    if (rstSyncToBusClkOut) begin
      clkDelReg <= spiBusRegPkg::clkDelDefault;
      txDataReg <= spiBusRegPkg::txDataDefault;
      startReq  <= 1'b0;
    end else begin
      // one busClk pulse per start write
      startReq <= startWr;
      if (regWr) begin
        case (busReq.address)
          spiBusRegPkg::clkDelRegAddr:     clkDelReg <= busReq.dataIn;
          // writes here only set the byte for the next transfer
          spiBusRegPkg::directDataRegAddr: txDataReg <= busReq.dataIn;
          default: ;
        endcase
      end
    end
  end

  // read data follows the address in the same cycle
  always_comb begin
    case (busReq.address)
      spiBusRegPkg::versionRegAddr:    dataOut = spiBusRegPkg::versionNum;
      spiBusRegPkg::transCtrlRegAddr:  dataOut = {7'b0000000, startReq};
      spiBusRegPkg::transStsRegAddr:   dataOut = {7'b0000000, xferStsReg};
      spiBusRegPkg::clkDelRegAddr:     dataOut = clkDelReg;
      spiBusRegPkg::directDataRegAddr: dataOut = rxDataReg;
      // control register and the SD card addresses read 0
      default:                         dataOut = 8'h00;
    endcase
  end

  ////////////////////////////////////////
  // reset generation
  ////////////////////////////////////////

  // reload while a cause is present, then drain one bit per cycle
  always_ff @(posedge busClk) begin
    if (rstFromWire || swRstWr) begin
      rstShift <= '1;
    end else begin
      rstShift <= rstShift >> 1;
    end
  end

  assign rstSyncToBusClkOut = rstShift[0];

  // double sync into the SPI domain
  always_ff @(posedge spiSysClk) begin
    rstSpiMeta         <= rstSyncToBusClkOut;
    rstSyncToSpiClkOut <= rstSpiMeta;
  end

  ////////////////////////////////////////
  // start toward spiSysClk
  ////////////////////////////////////////

  // stretch so that spiSysClk sees at least three samples
  always_ff @(posedge busClk) begin
    if (rstSyncToBusClkOut) begin
      startShift <= '0;
    end else if (startReq) begin
      startShift <= '1;
    end else begin
      startShift <= startShift >> 1;
    end
  end

  // three flop resync, rising edge gives a single pulse
  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClkOut) begin
      startSync  <= 3'b000;
      startPulse <= 1'b0;
    end else begin
      startSync  <= {startSync[1:0], startShift[0]};
      startPulse <= startSync[1] & ~startSync[2];
    end
  end

  // byte and divider settle long before the start pulse arrives
  always_ff @(posedge spiSysClk) begin
    txDataSpi   <= txDataReg;
    clkDelaySpi <= clkDelReg;
  end

  assign xferCtrl = '{start: startPulse, txData: txDataSpi, clkDelay: clkDelaySpi};

  ////////////////////////////////////////
  // busy back to busClk
  ////////////////////////////////////////

  always_ff @(posedge busClk) begin
    if (rstSyncToBusClkOut) begin
      busySync   <= 3'b000;
      xferStsReg <= 1'b0;
    end else begin
      busySync <= {busySync[1:0], xferStatus.busy};
      // status goes up at the write, down on falling synced busy
      if (startWr) begin
        xferStsReg <= 1'b1;
      end else if (busySync[2] && !busySync[1]) begin
        xferStsReg <= 1'b0;
      end
    end
  end

  // stable whenever status reads 0
  always_ff @(posedge busClk) begin
    rxDataReg <= xferStatus.rxData;
  end

endmodule

//--- hdl/spiTransEngine.sv
`timescale 1ns/1ps

module spiTransEngine (
  input  logic                     spiSysClk,
  input  logic                     rstSyncToSpiClkOut,
  input  spiLinkPkg::spiXferCtrl   xferCtrl,
  input  logic                     spiMiso,
  output spiLinkPkg::spiXferStatus xferStatus,
  output logic                     spiClk,
  output logic                     spiMosi,
  output logic                     spiCsN
);

  spiLinkPkg::engineState state;

  // byte and divider held for the whole frame
  spiBusRegPkg::regByte txLatch;
  spiLinkPkg::spiClkDiv divLatch;

  // one SPI bit period is two halves of divLatch+1 cycles
  logic [8:0] periodCnt;
  logic       periodEnd;

  logic                 busy;
  logic                 shiftLoad;
  logic                 shiftDone;
  spiBusRegPkg::regByte shiftRxByte;
  spiBusRegPkg::regByte rxLatch;

  assign periodEnd = (periodCnt == {divLatch, 1'b1});

  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClkOut) begin
      state     <= spiLinkPkg::engIdle;
      periodCnt <= '0;
      busy      <= 1'b0;
      spiCsN    <= 1'b1;
      shiftLoad <= 1'b0;
    end else begin
      shiftLoad <= 1'b0;
      case (state)
        spiLinkPkg::engIdle: begin
          periodCnt <= '0;
          // start is taken only here, later ones are dropped
          if (xferCtrl.start) begin
            state  <= spiLinkPkg::csSetup;
            busy   <= 1'b1;
            spiCsN <= 1'b0;
          end
        end
        spiLinkPkg::csSetup: begin
          // chip select low one bit time before the first edge
          if (periodEnd) begin
            periodCnt <= '0;
            shiftLoad <= 1'b1;
            state     <= spiLinkPkg::shift;
          end else begin
            periodCnt <= periodCnt + 1'b1;
          end
        end
        spiLinkPkg::shift: begin
          if (shiftDone) begin
            state <= spiLinkPkg::csHold;
          end
        end
        spiLinkPkg::csHold: begin
          // chip select stays low one bit time after the last bit
          if (periodEnd) begin
            state  <= spiLinkPkg::engIdle;
            busy   <= 1'b0;
            spiCsN <= 1'b1;
          end else begin
            periodCnt <= periodCnt + 1'b1;
          end
        end
        default: state <= spiLinkPkg::engIdle;
      endcase
    end
  end

  // frame payload, captured at start and at the end of shifting
  always_ff @(posedge spiSysClk) begin
    if (state == spiLinkPkg::engIdle && xferCtrl.start) begin
      txLatch  <= xferCtrl.txData;
      divLatch <= xferCtrl.clkDelay;
    end
    if (shiftDone) begin
      rxLatch <= shiftRxByte;
    end
  end

  assign xferStatus = '{busy: busy, rxData: rxLatch};

  spiBitShifter u_bitShifter (
    .spiSysClk          (spiSysClk),
    .rstSyncToSpiClkOut (rstSyncToSpiClkOut),
    .load               (shiftLoad),
    .txByte             (txLatch),
    .clkDelay           (divLatch),
    .spiMiso            (spiMiso),
    .done               (shiftDone),
    .rxByte             (shiftRxByte),
    .spiClk             (spiClk),
    .spiMosi            (spiMosi)
  );

endmodule

//--- hdl/spiBitShifter.sv
`timescale 1ns/1ps

module spiBitShifter (
  input  logic                 spiSysClk,
  input  logic                 rstSyncToSpiClkOut,
  input  logic                 load,
  input  spiBusRegPkg::regByte txByte,
  input  spiLinkPkg::spiClkDiv clkDelay,
  input  logic                 spiMiso,
  output logic                 done,
  output spiBusRegPkg::regByte rxByte,
  output logic                 spiClk,
  output logic                 spiMosi
);

  spiLinkPkg::shiftState state;

  // cycles spent in the current half bit
  spiLinkPkg::spiClkDiv halfCnt;
  logic                 halfEnd;

  // bit index within the byte, MSB first
  logic [2:0] bitCnt;

  spiBusRegPkg::regByte txShift;
  spiBusRegPkg::regByte rxShift;

  // each half bit lasts clkDelay+1 cycles
  assign halfEnd = (halfCnt == clkDelay);

  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClkOut) begin
      state   <= spiLinkPkg::shiftIdle;
      halfCnt <= '0;
      bitCnt  <= 3'd0;
      spiClk  <= 1'b0;
      done    <= 1'b0;
      txShift <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        spiLinkPkg::shiftIdle: begin
          halfCnt <= '0;
          bitCnt  <= 3'd0;
          // MSB goes on the line before the first rising edge
          if (load) begin
            txShift <= txByte;
            state   <= spiLinkPkg::lowPhase;
          end
        end
        spiLinkPkg::lowPhase: begin
          if (halfEnd) begin
            halfCnt <= '0;
            spiClk  <= 1'b1;
            state   <= spiLinkPkg::highPhase;
          end else begin
            halfCnt <= halfCnt + 1'b1;
          end
        end
        spiLinkPkg::highPhase: begin
          if (halfEnd) begin
            halfCnt <= '0;
            spiClk  <= 1'b0;
            if (bitCnt == 3'd7) begin
              done  <= 1'b1;
              state <= spiLinkPkg::shiftIdle;
            end else begin
              // next bit on the falling edge
              bitCnt  <= bitCnt + 1'b1;
              txShift <= {txShift[6:0], 1'b0};
              state   <= spiLinkPkg::lowPhase;
            end
          end else begin
            halfCnt <= halfCnt + 1'b1;
          end
        end
        default: state <= spiLinkPkg::shiftIdle;
      endcase
    end
  end

  // MISO sampled on the edge where spiClk rises
  always_ff @(posedge spiSysClk) begin
    if (state == spiLinkPkg::lowPhase && halfEnd) begin
      rxShift <= {rxShift[6:0], spiMiso};
    end
  end

  assign spiMosi = txShift[7];
  assign rxByte  = rxShift;

endmodule

//--- hdl/spiLinkPkg.sv
package spiLinkPkg;

  // half bit length minus one, in spiSysClk cycles
  typedef logic [7:0] spiClkDiv;

  // register block to transfer engine, all on spiSysClk
  typedef struct packed {
    // one spiSysClk pulse per start request
    logic                 start;
    // byte to send, taken by the engine at start
    spiBusRegPkg::regByte txData;
    spiClkDiv             clkDelay;
  } spiXferCtrl;

  // transfer engine back to the register block
  typedef struct packed {
    // high from accepted start to the end of csHold
    logic                 busy;
    // last received byte, only changes while busy
    spiBusRegPkg::regByte rxData;
  } spiXferStatus;

  // frame sequencing in the transfer engine
  typedef enum logic [1:0] {
    engIdle,
    csSetup,
    shift,
    csHold
  } engineState;

  // SPI clock phases in the bit shifter
  typedef enum logic [1:0] {
    shiftIdle,
    lowPhase,
    highPhase
  } shiftState;

endpackage

//--- hdl/spiBusRegPkg.sv
package spiBusRegPkg;

  ////////////////////////////////////////
  // register bus types
  ////////////////////////////////////////

  // one byte of register data
  typedef logic [7:0] regByte;

  // byte-wide register address
  typedef logic [7:0] regAddr;

  // host request, sampled on busClk
  typedef struct packed {
    regAddr address;
    regByte dataIn;
    // high for a write, low for a read
    logic   writeEn;
    // qualifies the whole request
    logic   strobe;
    // selects this register block on a shared bus
    logic   ctrlStsRegSel;
  } regBusReq;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  localparam regAddr versionRegAddr    = 8'h00;
  localparam regAddr controlRegAddr    = 8'h01;
  localparam regAddr transCtrlRegAddr  = 8'h03;
  localparam regAddr transStsRegAddr   = 8'h04;
  localparam regAddr clkDelRegAddr     = 8'h0A;
  localparam regAddr directDataRegAddr = 8'h0B;

  // bit positions inside the control registers
  localparam int swRstBit      = 0;
  localparam int transStartBit = 0;

  ////////////////////////////////////////
  // constants and reset values
  ////////////////////////////////////////

  localparam regByte versionNum    = 8'h01;
  // divider 4 gives a half bit of 5 spiSysClk cycles
  localparam regByte clkDelDefault = 8'h04;
  localparam regByte txDataDefault = 8'h00;

endpackage
